// ==== hdl/dbg_ahb_settings.svh ====
// Debug AHB bridge settings

`ifndef DBG_AHB_SETTINGS_SVH
`define DBG_AHB_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Bridge dimensions
////////////////////////////////////////////////////////////

// Address and data bus widths
`define DBG_ADDR_WIDTH 32
`define DBG_DATA_WIDTH 32

// Number of bus interface units, one AHB master port each
`define DBG_NUM_PORTS 2

// Byte lane order, 1 for little endian and 0 for big endian
`define DBG_LITTLE_ENDIAN 1

////////////////////////////////////////////////////////////
// AHB-Lite encodings
////////////////////////////////////////////////////////////

// HTRANS, only single transfers are issued
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// HSIZE
`define HSIZE_BYTE  3'b000
`define HSIZE_HWORD 3'b001
`define HSIZE_WORD  3'b010

`endif

// ==== hdl/dbg_ahb_pkg.sv ====
// Debug AHB bridge types

`include "dbg_ahb_settings.svh"

package dbg_ahb_pkg;

  ////////////////////////////////////////////////////////////
  // Basic vectors
  ////////////////////////////////////////////////////////////

  // Width of the port number, at least one bit
  localparam int unsigned PORT_SEL_WIDTH =
    (`DBG_NUM_PORTS > 1) ? $clog2(`DBG_NUM_PORTS) : 1;

  typedef logic [`DBG_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DBG_DATA_WIDTH-1:0] data_t;

  // Access size as a byte count, 1, 2 or 4
  typedef logic [2:0] word_size_t;

  typedef logic [PORT_SEL_WIDTH-1:0] port_sel_t;

  ////////////////////////////////////////////////////////////
  // Debug side
  ////////////////////////////////////////////////////////////

  // One command from the debug unit
  typedef struct packed {
    addr_t      addr;
    data_t      wdata;
    logic       write;
    word_size_t word_size;
  } dbg_cmd_t;

  // Result of one command, read data is low justified
  typedef struct packed {
    data_t rdata;
    logic  err;
  } dbg_rsp_t;

  ////////////////////////////////////////////////////////////
  // AHB-Lite side
  ////////////////////////////////////////////////////////////

  // Master outputs of one port
  typedef struct packed {
    addr_t      haddr;
    data_t      hwdata;
    logic       hwrite;
    logic [2:0] hsize;
    logic [1:0] htrans;
  } ahb_req_t;

  // Slave responses of one port
  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_rsp_t;

  // Transfer FSM of a bus interface unit
  typedef enum logic [1:0] {
    st_idle,
    st_address,
    st_data
  } biu_state_e;

endpackage

// ==== hdl/dbg_cmd_dispatch.sv ====
// Debug command dispatcher

`timescale 1ns/1ps

`include "dbg_ahb_settings.svh"

module dbg_cmd_dispatch (
  input  logic                        tck,
  input  logic                        ahb_rstn,
  input  logic                        cmd_strb,
  input  dbg_ahb_pkg::port_sel_t      cmd_port,
  input  logic [`DBG_NUM_PORTS-1:0]   rdy,
  output logic                        cmd_rdy,
  output logic [`DBG_NUM_PORTS-1:0]   strb,
  output logic                        tck_rstn
);

  import dbg_ahb_pkg::*;

  ////////////////////////////////////////////////////////////
  // Reset synchronizer
  ////////////////////////////////////////////////////////////

  // Asserts at once, releases after two tck edges
  logic [1:0] rstn_sync;

  always_ff @(posedge tck or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rstn_sync <= 2'b00;
    end else begin
      rstn_sync <= {rstn_sync[0], 1'b1};
    end
  end

  // Shared by every tck flop in the bridge
  assign tck_rstn = rstn_sync[1];

  ////////////////////////////////////////////////////////////
  // Command routing
  ////////////////////////////////////////////////////////////

  // One-hot strobe towards the addressed unit
  // The addressed unit also supplies the ready level
  // A port number past the last unit sees no ready and gets no strobe
  always_comb begin
    strb    = '0;
    cmd_rdy = 1'b0;
    for (int i = 0; i < `DBG_NUM_PORTS; i++) begin
      if (port_sel_t'(i) == cmd_port) begin
        // Each unit latches only when its own ready is high
        strb[i] = cmd_strb;
        cmd_rdy = rdy[i];
      end
    end
  end

endmodule

// ==== hdl/dbg_ahb_biu.sv ====
// Debug AHB-Lite bus interface unit

`timescale 1ns/1ps

`include "dbg_ahb_settings.svh"

module dbg_ahb_biu (
  // Debug side, tck domain
  input  logic                  tck,
  input  logic                  tck_rstn,
  input  dbg_ahb_pkg::dbg_cmd_t cmd,
  input  logic                  strb,
  output logic                  rdy,
  output dbg_ahb_pkg::dbg_rsp_t rsp,
  // Bus side, HCLK domain
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  output dbg_ahb_pkg::ahb_req_t ahb_req,
  input  dbg_ahb_pkg::ahb_rsp_t ahb_rsp
);

  import dbg_ahb_pkg::*;

  // Byte lanes on the data bus
  localparam int unsigned LANES     = `DBG_DATA_WIDTH / 8;
  localparam int unsigned LANE_BITS = $clog2(LANES);
  // Lane index is mirrored for big endian
  localparam logic        LANE_FLIP = (`DBG_LITTLE_ENDIAN == 0);

  // Command latched in tck, held stable while rdy is low
  addr_t      haddr_q;
  data_t      hwdata_q;
  logic       hwrite_q;
  logic [2:0] hsize_q;

  // Toggle handshake between the domains
  logic       start_tgl;
  logic       rdy_tgl;
  logic [2:0] rdy_sync;
  logic [2:0] start_sync;

  // HCLK side control
  logic [1:0] hrstn_sync;
  logic       hclk_rstn;
  logic       start_edge;
  logic       start_hold;
  logic       start_req;
  logic       xfer_ack;
  biu_state_e state;
  logic [1:0] htrans_q;

  // Response registers
  data_t                rdata_q;
  data_t                rdata_lane;
  logic                 err_q;
  logic [LANE_BITS-1:0] byte_lane;
  logic [LANE_BITS-2:0] hword_lane;

  logic accept;

  ////////////////////////////////////////////////////////////
  // tck domain
  ////////////////////////////////////////////////////////////

  assign accept = strb & rdy;

  // Address, direction and size of the next transfer
  always_ff @(posedge tck or negedge tck_rstn) begin
    if (!tck_rstn) begin
      haddr_q  <= '0;
      hwrite_q <= 1'b0;
      hsize_q  <= `HSIZE_WORD;
    end else if (accept) begin
      haddr_q  <= cmd.addr;
      hwrite_q <= cmd.write;
      case (cmd.word_size)
        3'd1:    hsize_q <= `HSIZE_BYTE;
        3'd2:    hsize_q <= `HSIZE_HWORD;
        default: hsize_q <= `HSIZE_WORD;
      endcase
    end
  end

  // Narrow write data goes out on every lane
  always_ff @(posedge tck) begin
    if (accept) begin
      case (cmd.word_size)
        3'd1:    hwdata_q <= {LANES{cmd.wdata[7:0]}};
        3'd2:    hwdata_q <= {(LANES / 2){cmd.wdata[15:0]}};
        default: hwdata_q <= cmd.wdata;
      endcase
    end
  end

  // Start toggle, ready level and ready toggle synchronizer
  always_ff @(posedge tck or negedge tck_rstn) begin
    if (!tck_rstn) begin
      start_tgl <= 1'b0;
      rdy_sync  <= 3'b000;
      rdy       <= 1'b1;
    end else begin
      rdy_sync <= {rdy_sync[1:0], rdy_tgl};
      if (accept) begin
        start_tgl <= ~start_tgl;
        rdy       <= 1'b0;
      end else if (rdy_sync[2] != rdy_sync[1]) begin
        rdy <= 1'b1;
      end
    end
  end

  assign rsp = '{rdata: rdata_q, err: err_q};

  ////////////////////////////////////////////////////////////
  // HCLK domain
  ////////////////////////////////////////////////////////////

  // Local reset, released on HCLK
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      hrstn_sync <= 2'b00;
    end else begin
      hrstn_sync <= {hrstn_sync[0], 1'b1};
    end
  end

  assign hclk_rstn = hrstn_sync[1];

  // Two sync flops plus one for edge detect
  always_ff @(posedge HCLK or negedge hclk_rstn) begin
    if (!hclk_rstn) begin
      start_sync <= 3'b000;
    end else begin
      start_sync <= {start_sync[1:0], start_tgl};
    end
  end

  assign start_edge = start_sync[2] != start_sync[1];
  assign start_req  = start_edge | start_hold;

  // Keep a start seen while a transfer is still running
  always_ff @(posedge HCLK or negedge hclk_rstn) begin
    if (!hclk_rstn) begin
      start_hold <= 1'b0;
    end else begin
      start_hold <= start_req & (state != st_idle);
    end
  end

  assign xfer_ack = ahb_rsp.hready & (state == st_data);

  // Single NONSEQ cycle, then wait out the data phase
  always_ff @(posedge HCLK or negedge hclk_rstn) begin
    if (!hclk_rstn) begin
      state    <= st_idle;
      htrans_q <= `HTRANS_IDLE;
    end else begin
      case (state)
        st_idle: begin
          if (start_req) begin
            htrans_q <= `HTRANS_NONSEQ;
            state    <= st_address;
          end
        end
        st_address: begin
          htrans_q <= `HTRANS_IDLE;
          state    <= st_data;
        end
        st_data: begin
          if (ahb_rsp.hready) begin
            state <= st_idle;
          end
        end
        default: begin
          htrans_q <= `HTRANS_IDLE;
          state    <= st_idle;
        end
      endcase
    end
  end

  // Addressed lane moved down and zero extended
  assign byte_lane  = haddr_q[LANE_BITS-1:0] ^ {LANE_BITS{LANE_FLIP}};
  assign hword_lane = haddr_q[LANE_BITS-1:1] ^ {(LANE_BITS - 1){LANE_FLIP}};

  always_comb begin
    case (hsize_q)
      `HSIZE_BYTE:  rdata_lane = data_t'(ahb_rsp.hrdata[8 * byte_lane +: 8]);
      `HSIZE_HWORD: rdata_lane = data_t'(ahb_rsp.hrdata[16 * hword_lane +: 16]);
      default:      rdata_lane = ahb_rsp.hrdata;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (xfer_ack) begin
      rdata_q <= rdata_lane;
    end
  end

  // Error flag and completion toggle back to tck
  always_ff @(posedge HCLK or negedge hclk_rstn) begin
    if (!hclk_rstn) begin
      err_q   <= 1'b0;
      rdy_tgl <= 1'b0;
    end else if (xfer_ack) begin
      err_q   <= ahb_rsp.hresp;
      rdy_tgl <= ~rdy_tgl;
    end
  end

  assign ahb_req = '{
    haddr:  haddr_q,
    hwdata: hwdata_q,
    hwrite: hwrite_q,
    hsize:  hsize_q,
    htrans: htrans_q
  };

endmodule

// ==== hdl/dbg_rsp_collect.sv ====
// Debug response collector

`timescale 1ns/1ps

`include "dbg_ahb_settings.svh"

module dbg_rsp_collect (
  input  logic                      tck,
  input  logic                      tck_rstn,
  input  logic [`DBG_NUM_PORTS-1:0] rdy,
  input  dbg_ahb_pkg::dbg_rsp_t     rsp [`DBG_NUM_PORTS],
  output logic                      rsp_valid,
  output dbg_ahb_pkg::port_sel_t    rsp_port,
  output dbg_ahb_pkg::dbg_rsp_t     rsp_out
);

  import dbg_ahb_pkg::*;

  logic [`DBG_NUM_PORTS-1:0] rdy_q;
  logic [`DBG_NUM_PORTS-1:0] pending;
  // Pending ports including the ones finishing right now
  logic [`DBG_NUM_PORTS-1:0] cand;
  logic [`DBG_NUM_PORTS-1:0] clr;
  logic                      found;
  port_sel_t                 sel;

  ////////////////////////////////////////////////////////////
  // Port selection
  ////////////////////////////////////////////////////////////

  // Lowest numbered port wins, scan runs downwards
  always_comb begin
    cand  = pending | (rdy & ~rdy_q);
    found = 1'b0;
    sel   = '0;
    clr   = '0;
    for (int i = `DBG_NUM_PORTS - 1; i >= 0; i--) begin
      if (cand[i]) begin
        found = 1'b1;
        sel   = port_sel_t'(i);
      end
    end
    if (found) begin
      clr[sel] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Queue and output registers
  ////////////////////////////////////////////////////////////

  // Units come out of reset ready, so no edge is seen then
  always_ff @(posedge tck or negedge tck_rstn) begin
    if (!tck_rstn) begin
      rdy_q     <= '1;
      pending   <= '0;
      rsp_valid <= 1'b0;
      rsp_port  <= '0;
    end else begin
      rdy_q     <= rdy;
      pending   <= cand & ~clr;
      rsp_valid <= found;
      if (found) begin
        rsp_port <= sel;
      end
    end
  end

  // Unit response is stable while its rdy is high
  always_ff @(posedge tck) begin
    if (found) begin
      rsp_out <= rsp[sel];
    end
  end

endmodule

// ==== hdl/dbg_ahb_bridge.sv ====
// Debug AHB bridge top level

`timescale 1ns/1ps

`include "dbg_ahb_settings.svh"

module dbg_ahb_bridge (
  input  logic                   tck,
  input  logic                   HCLK,
  input  logic                   ahb_rstn,
  // Debug command, tck domain
  input  logic                   cmd_strb,
  input  dbg_ahb_pkg::port_sel_t cmd_port,
  input  dbg_ahb_pkg::dbg_cmd_t  cmd,
  output logic                   cmd_rdy,
  // Tagged response, tck domain
  output logic                   rsp_valid,
  output dbg_ahb_pkg::port_sel_t rsp_port,
  output dbg_ahb_pkg::dbg_rsp_t  rsp,
  // AHB-Lite master ports, HCLK domain
  output dbg_ahb_pkg::ahb_req_t  ahb_req [`DBG_NUM_PORTS],
  input  dbg_ahb_pkg::ahb_rsp_t  ahb_rsp [`DBG_NUM_PORTS]
);

  import dbg_ahb_pkg::*;

  logic                      tck_rstn;
  logic [`DBG_NUM_PORTS-1:0] unit_strb;
  logic [`DBG_NUM_PORTS-1:0] unit_rdy;
  dbg_rsp_t                  unit_rsp [`DBG_NUM_PORTS];

  // Port decode and tck reset
  dbg_cmd_dispatch dispatch_i (
    .tck      (tck),
    .ahb_rstn (ahb_rstn),
    .cmd_strb (cmd_strb),
    .cmd_port (cmd_port),
    .rdy      (unit_rdy),
    .cmd_rdy  (cmd_rdy),
    .strb     (unit_strb),
    .tck_rstn (tck_rstn)
  );

  ////////////////////////////////////////////////////////////
  // One bus interface unit per AHB port
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `DBG_NUM_PORTS; i++) begin : g_biu
    dbg_ahb_biu biu_i (
      .tck      (tck),
      .tck_rstn (tck_rstn),
      .cmd      (cmd),
      .strb     (unit_strb[i]),
      .rdy      (unit_rdy[i]),
      .rsp      (unit_rsp[i]),
      .HCLK     (HCLK),
      .ahb_rstn (ahb_rstn),
      .ahb_req  (ahb_req[i]),
      .ahb_rsp  (ahb_rsp[i])
    );
  end

  // Finished units drained one per tck cycle
  dbg_rsp_collect collect_i (
    .tck       (tck),
    .tck_rstn  (tck_rstn),
    .rdy       (unit_rdy),
    .rsp       (unit_rsp),
    .rsp_valid (rsp_valid),
    .rsp_port  (rsp_port),
    .rsp_out   (rsp)
  );

endmodule

// ==== test/ahb_mem_model.sv ====
// AHB-Lite memory model

`timescale 1ns/1ps

`include "dbg_ahb_settings.svh"

module ahb_mem_model #(
  parameter int SEED = 32'h624a_9fdb
) (
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  dbg_ahb_pkg::ahb_req_t ahb_req,
  output dbg_ahb_pkg::ahb_rsp_t ahb_rsp
);

  import dbg_ahb_pkg::*;

  // 256 words, address bit 12 is not decoded for storage
  data_t      mem [256];
  int         seed;

  // Data phase state
  logic       busy;
  logic [1:0] wait_cnt;
  logic       err;
  logic       err_last;
  addr_t      addr_q;
  logic       write_q;
  logic [2:0] size_q;

  // Fill pattern from the word index
  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h5a3c_0000 ^ (i * 32'h0001_0203);
    end
  end

  ////////////////////////////////////////////////////////////
  // Slave response
  ////////////////////////////////////////////////////////////

  // Wait states first, then a two cycle error or a single okay cycle
  always_comb begin
    ahb_rsp.hrdata = '0;
    ahb_rsp.hready = 1'b1;
    ahb_rsp.hresp  = 1'b0;
    if (busy) begin
      if (!write_q && !err) begin
        ahb_rsp.hrdata = mem[addr_q[9:2]];
      end
      if (wait_cnt != 2'd0) begin
        ahb_rsp.hready = 1'b0;
      end else if (err && !err_last) begin
        ahb_rsp.hready = 1'b0;
        ahb_rsp.hresp  = 1'b1;
      end else begin
        ahb_rsp.hresp = err;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Transfer sequencing
  ////////////////////////////////////////////////////////////

  always @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
      err      <= 1'b0;
      err_last <= 1'b0;
      addr_q   <= '0;
      write_q  <= 1'b0;
      size_q   <= `HSIZE_WORD;
    end else begin
      if (busy && wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else if (busy && err && !err_last) begin
        err_last <= 1'b1;
      end else if (busy) begin
        busy <= 1'b0;
        // Little-endian lanes picked by address and size
        if (write_q && !err) begin
          case (size_q)
            `HSIZE_BYTE:
              mem[addr_q[9:2]][8 * addr_q[1:0] +: 8] <= ahb_req.hwdata[8 * addr_q[1:0] +: 8];
            `HSIZE_HWORD:
              mem[addr_q[9:2]][16 * addr_q[1] +: 16] <= ahb_req.hwdata[16 * addr_q[1] +: 16];
            default:
              mem[addr_q[9:2]] <= ahb_req.hwdata;
          endcase
        end
      end
      // Address phase sampled while hready is high
      if (ahb_rsp.hready && ahb_req.htrans == `HTRANS_NONSEQ) begin
        busy     <= 1'b1;
        addr_q   <= ahb_req.haddr;
        write_q  <= ahb_req.hwrite;
        size_q   <= ahb_req.hsize;
        err      <= ahb_req.haddr[12];
        err_last <= 1'b0;
        wait_cnt <= 2'($random(seed));
      end
    end
  end

endmodule

// ==== test/dbg_ahb_bridge_tb.sv ====
// Debug AHB bridge testbench

`timescale 1ns/1ps

`include "dbg_ahb_settings.svh"

module dbg_ahb_bridge_tb;

  import dbg_ahb_pkg::*;

  localparam int NPORTS  = `DBG_NUM_PORTS;
  localparam int TIMEOUT = 400;
  localparam int SEED    = 32'h624a_9fdb;

  // One row of the stimulus table, names kept alongside
  typedef struct packed {
    port_sel_t port;
    dbg_cmd_t  cmd;
    logic      no_wait;
    data_t     exp_rdata;
    logic      exp_err;
  } stim_row_t;

  logic      tck;
  logic      HCLK;
  logic      ahb_rstn;
  logic      cmd_strb;
  port_sel_t cmd_port;
  dbg_cmd_t  cmd;
  logic      cmd_rdy;
  logic      rsp_valid;
  port_sel_t rsp_port;
  dbg_rsp_t  rsp;
  ahb_req_t  ahb_req [NPORTS];
  ahb_rsp_t  ahb_rsp [NPORTS];

  stim_row_t rows [$];
  string     row_names [$];
  // Row numbers of accepted commands still waiting for a response
  int        in_flight [$];

  ////////////////////////////////////////////////////////////
  // Clocks, DUT and slaves
  ////////////////////////////////////////////////////////////

  initial begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  // tck lags HCLK by 30 ns
  initial begin
    tck = 1'b0;
    #30;
    forever #50 tck = ~tck;
  end

  dbg_ahb_bridge dut_i (
    .tck       (tck),
    .HCLK      (HCLK),
    .ahb_rstn  (ahb_rstn),
    .cmd_strb  (cmd_strb),
    .cmd_port  (cmd_port),
    .cmd       (cmd),
    .cmd_rdy   (cmd_rdy),
    .rsp_valid (rsp_valid),
    .rsp_port  (rsp_port),
    .rsp       (rsp),
    .ahb_req   (ahb_req),
    .ahb_rsp   (ahb_rsp)
  );

  // Each port gets its own wait state sequence
  for (genvar i = 0; i < NPORTS; i++) begin : g_mem
    ahb_mem_model #(.SEED(SEED ^ i)) mem_i (
      .HCLK     (HCLK),
      .ahb_rstn (ahb_rstn),
      .ahb_req  (ahb_req[i]),
      .ahb_rsp  (ahb_rsp[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s rdata expected %08h actual %08h",
                               name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s err expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_port(input string name, input port_sel_t exp, input port_sel_t act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s rsp_port expected %0d actual %0d",
                               name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_htrans(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s htrans expected %b actual %b",
                               name, exp, act));
    end
  endtask

  // Responses matched by port, a lone command must answer on its own port
  always @(negedge tck) begin : match_responses
    int pos;
    int idx;
    if (rsp_valid === 1'b1) begin
      pos = -1;
      if (in_flight.size() == 1) begin
        pos = 0;
      end else begin
        for (int k = in_flight.size() - 1; k >= 0; k--) begin
          if (rows[in_flight[k]].port == rsp_port) begin
            pos = k;
          end
        end
      end
      if (pos < 0) begin
        report_failure($sformatf("Response on port %0d with no command in flight", rsp_port));
      end else begin
        idx = in_flight[pos];
        check_port(row_names[idx], rows[idx].port, rsp_port);
        check_data(row_names[idx], rows[idx].exp_rdata, rsp.rdata);
        check_err(row_names[idx], rows[idx].exp_err, rsp.err);
        in_flight.delete(pos);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input int port, input addr_t addr,
                         input data_t wdata, input logic write, input int size,
                         input logic no_wait, input data_t exp_rdata, input logic exp_err);
    stim_row_t row;
    row.port          = port_sel_t'(port);
    row.cmd.addr      = addr;
    row.cmd.wdata     = wdata;
    row.cmd.write     = write;
    row.cmd.word_size = word_size_t'(size);
    row.no_wait       = no_wait;
    row.exp_rdata     = exp_rdata;
    row.exp_err       = exp_err;
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  // Called and returns 10 ns after a tck edge
  task automatic issue_row(input int idx);
    int cycles;
    cycles   = 0;
    cmd_port = rows[idx].port;
    cmd      = rows[idx].cmd;
    cmd_strb = 1'b1;
    @(negedge tck);
    while (cmd_rdy !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure($sformatf("Timeout waiting for cmd_rdy in %s", row_names[idx]));
      end
      @(negedge tck);
    end
    // Accepted on this edge
    @(posedge tck);
    in_flight.push_back(idx);
    #10;
    cmd_strb = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (in_flight.size() != 0) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure("Timeout waiting for rsp_valid");
      end
      @(posedge tck);
      #10;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    cmd_strb = 1'b0;
    cmd_port = '0;
    cmd      = '0;
    ahb_rstn = 1'b0;

    // Word write then read back
    add_row("word_wr_p0", 0, 32'h10, 32'h1122_3344, 1'b1, 4, 1'b0, 32'h0, 1'b0);
    add_row("word_rd_p0", 0, 32'h10, 32'h0, 1'b0, 4, 1'b0, 32'h1122_3344, 1'b0);
    // Byte lanes, upper write bits must be ignored
    add_row("byte_wr_0", 1, 32'h20, 32'h0000_00a1, 1'b1, 1, 1'b0, 32'h0, 1'b0);
    add_row("byte_wr_1", 1, 32'h21, 32'hffff_ffb2, 1'b1, 1, 1'b0, 32'h0, 1'b0);
    add_row("byte_wr_2", 1, 32'h22, 32'h0000_00c3, 1'b1, 1, 1'b0, 32'h0, 1'b0);
    add_row("byte_wr_3", 1, 32'h23, 32'h0000_00d4, 1'b1, 1, 1'b0, 32'h0, 1'b0);
    add_row("word_rd_bytes", 1, 32'h20, 32'h0, 1'b0, 4, 1'b0, 32'hd4c3_b2a1, 1'b0);
    add_row("byte_rd_2", 1, 32'h22, 32'h0, 1'b0, 1, 1'b0, 32'h0000_00c3, 1'b0);
    add_row("byte_rd_3", 1, 32'h23, 32'h0, 1'b0, 1, 1'b0, 32'h0000_00d4, 1'b0);
    add_row("hword_rd_2", 1, 32'h22, 32'h0, 1'b0, 2, 1'b0, 32'h0000_d4c3, 1'b0);
    // Halfword lanes
    add_row("hword_wr_0", 0, 32'h30, 32'h0000_5566, 1'b1, 2, 1'b0, 32'h0, 1'b0);
    add_row("hword_wr_2", 0, 32'h32, 32'haaaa_7788, 1'b1, 2, 1'b0, 32'h0, 1'b0);
    add_row("word_rd_hwords", 0, 32'h30, 32'h0, 1'b0, 4, 1'b0, 32'h7788_5566, 1'b0);
    add_row("hword_rd_0", 0, 32'h30, 32'h0, 1'b0, 2, 1'b0, 32'h0000_5566, 1'b0);
    // Error region aliases the same storage word
    add_row("err_base_wr", 0, 32'h40, 32'hcafe_f00d, 1'b1, 4, 1'b0, 32'h0, 1'b0);
    add_row("err_wr", 0, 32'h1040, 32'hdead_beef, 1'b1, 4, 1'b0, 32'h0, 1'b1);
    add_row("err_rd", 0, 32'h1040, 32'h0, 1'b0, 4, 1'b0, 32'h0, 1'b1);
    add_row("err_unchanged", 0, 32'h40, 32'h0, 1'b0, 4, 1'b0, 32'hcafe_f00d, 1'b0);
    // Both ports in flight together
    add_row("par_wr_p0", 0, 32'h50, 32'h0a0a_5050, 1'b1, 4, 1'b0, 32'h0, 1'b0);
    add_row("par_wr_p1", 1, 32'h50, 32'h1b1b_6161, 1'b1, 4, 1'b1, 32'h0, 1'b0);
    add_row("par_rd_p0", 0, 32'h50, 32'h0, 1'b0, 4, 1'b1, 32'h0a0a_5050, 1'b0);
    add_row("par_rd_p1", 1, 32'h50, 32'h0, 1'b0, 4, 1'b1, 32'h1b1b_6161, 1'b0);
    add_row("par_byte_p1", 1, 32'h51, 32'h0, 1'b0, 1, 1'b1, 32'h0000_0061, 1'b0);
    add_row("par_hword_p0", 0, 32'h52, 32'h0, 1'b0, 2, 1'b1, 32'h0000_0a0a, 1'b0);

    // Reset held for 4 cycles
    repeat (4) @(posedge tck);
    #10;
    ahb_rstn = 1'b1;
    repeat (3) @(posedge tck);

    // Idle state straight after reset
    for (int p = 0; p < NPORTS; p++) begin
      @(posedge tck);
      #10;
      cmd_port = port_sel_t'(p);
      @(negedge tck);
      check_flag($sformatf("reset_cmd_rdy_p%0d", p), 1'b1, cmd_rdy);
      check_flag($sformatf("reset_rsp_valid_p%0d", p), 1'b0, rsp_valid);
      check_htrans($sformatf("reset_htrans_p%0d", p), `HTRANS_IDLE, ahb_req[p].htrans);
    end
    @(posedge tck);
    #10;

    foreach (rows[i]) begin
      if (!rows[i].no_wait) begin
        wait_drained();
      end
      issue_row(i);
    end
    wait_drained();
    repeat (4) @(posedge tck);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== dbg_ahb_bridge.f ====
+incdir+hdl
hdl/dbg_ahb_pkg.sv
hdl/dbg_cmd_dispatch.sv
hdl/dbg_ahb_biu.sv
hdl/dbg_rsp_collect.sv
hdl/dbg_ahb_bridge.sv
test/ahb_mem_model.sv
test/dbg_ahb_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: dbg_ahb_bridge

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dbg_ahb_pkg.sv
      - hdl/dbg_cmd_dispatch.sv
      - hdl/dbg_ahb_biu.sv
      - hdl/dbg_rsp_collect.sv
      - hdl/dbg_ahb_bridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/ahb_mem_model.sv
      - test/dbg_ahb_bridge_tb.sv
